// ==== logic/cache_pkg.sv ====
package cache_pkg;

  // Processor and memory bus widths.
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;

  // Byte address bits inside one data word.
  localparam int BYTE_OFFSET_WIDTH = $clog2(DATA_WIDTH / 8);

  typedef logic [DATA_WIDTH-1:0] word_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // {write enable, set valid, set dirty, strategy enable, offset select}.
  typedef logic [4:0] ctrl_t;

  typedef enum logic [1:0] {
    REPL_FIFO,
    REPL_LRU,
    REPL_RANDOM
  } replace_mode_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_COMPARE,
    ST_WRITEBACK,
    ST_REFILL,
    ST_DONE
  } cache_state_e;

endpackage : cache_pkg

// ==== logic/cache_line.sv ====
`timescale 1ns/1ps

module cache_line #(
  parameter int  NUM_SETS     = 4,
  parameter int  OFFSET_WIDTH = 4,
  localparam int INDEX_WIDTH  = $clog2(NUM_SETS),
  localparam int TAG_WIDTH    = cache_pkg::ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH,
  localparam int WORD_BITS    = OFFSET_WIDTH - cache_pkg::BYTE_OFFSET_WIDTH
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 write_en_i,
  input  logic                 set_valid_i,
  input  logic                 set_dirty_i,
  input  logic [TAG_WIDTH-1:0] set_tag_i,
  input  logic [WORD_BITS-1:0] offset_i,
  input  cache_pkg::word_t     write_data_i,
  output logic                 valid_o,
  output logic                 dirty_o,
  output logic [TAG_WIDTH-1:0] tag_o,
  output logic                 hit_o,
  output cache_pkg::word_t     read_data_o
);

  localparam int WORDS = 2 ** WORD_BITS;

  logic                 valid_q;
  logic                 dirty_q;
  logic [TAG_WIDTH-1:0] tag_q;
  cache_pkg::word_t     data_q [WORDS];

  // Line state bits.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      dirty_q <= 1'b0;
    end else if (write_en_i) begin
      valid_q <= set_valid_i;
      dirty_q <= set_dirty_i; // Refill writes clear it again.
    end
  end

  always_ff @(posedge clk_i) begin
    if (write_en_i) begin
      tag_q            <= set_tag_i;
      data_q[offset_i] <= write_data_i;
    end
  end

  assign valid_o     = valid_q;
  assign dirty_o     = dirty_q;
  assign tag_o       = tag_q;
  assign hit_o       = valid_q && (tag_q == set_tag_i);
  assign read_data_o = data_q[offset_i]; // Asynchronous word read.

endmodule : cache_line

// ==== logic/replace_controller.sv ====
`timescale 1ns/1ps

module replace_controller #(
  parameter int                       SET_SIZE     = 2,
  parameter cache_pkg::replace_mode_e REPLACE_MODE = cache_pkg::REPL_LRU
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                en_i,
  input  logic [SET_SIZE-1:0] valid_line_i,
  input  logic [SET_SIZE-1:0] hit_line_i,
  output logic [SET_SIZE-1:0] out_line_o
);

  localparam int SEL_WIDTH = (SET_SIZE > 1) ? $clog2(SET_SIZE) : 1;

  logic [SEL_WIDTH-1:0] fifo_ptr_q;
  logic [SEL_WIDTH-1:0] age_q [SET_SIZE];
  logic [15:0]          lfsr_q;
  logic [SEL_WIDTH-1:0] hit_idx;
  logic [SEL_WIDTH-1:0] oldest_idx;
  logic [SEL_WIDTH-1:0] invalid_idx;
  logic                 any_invalid;
  logic [SEL_WIDTH-1:0] policy_idx;

  // Walk downward so the lowest matching way wins.
  always_comb begin
    hit_idx     = '0;
    oldest_idx  = '0;
    invalid_idx = '0;
    any_invalid = 1'b0;
    for (int i = SET_SIZE - 1; i >= 0; i--) begin
      if (hit_line_i[i]) hit_idx = SEL_WIDTH'(i);
      if (age_q[i] == SEL_WIDTH'(SET_SIZE - 1)) oldest_idx = SEL_WIDTH'(i);
      if (!valid_line_i[i]) begin
        any_invalid = 1'b1;
        invalid_idx = SEL_WIDTH'(i);
      end
    end
  end

  always_comb begin
    case (REPLACE_MODE)
      cache_pkg::REPL_FIFO: policy_idx = fifo_ptr_q;
      cache_pkg::REPL_LRU:  policy_idx = oldest_idx;
      default:              policy_idx = SEL_WIDTH'(lfsr_q % SET_SIZE);
    endcase
  end

  assign out_line_o = SET_SIZE'(1) << (any_invalid ? invalid_idx : policy_idx);

  // Pointer moves on once the way it names has been refilled and used.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fifo_ptr_q <= '0;
    end else if (en_i && hit_line_i[fifo_ptr_q]) begin
      fifo_ptr_q <= (fifo_ptr_q == SEL_WIDTH'(SET_SIZE - 1)) ? '0 : fifo_ptr_q + 1'b1;
    end
  end

  // Ages form a permutation, 0 is most recent.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < SET_SIZE; i++) age_q[i] <= SEL_WIDTH'(i);
    end else if (en_i && |hit_line_i) begin
      for (int i = 0; i < SET_SIZE; i++) begin
        if (SEL_WIDTH'(i) == hit_idx) age_q[i] <= '0;
        else if (age_q[i] < age_q[hit_idx]) age_q[i] <= age_q[i] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lfsr_q <= 16'hace1;
    end else if (en_i) begin // Steps only on accesses, victim holds through a miss.
      lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
    end
  end

endmodule : replace_controller

// ==== logic/cache_set.sv ====
`timescale 1ns/1ps

module cache_set #(
  parameter int                       SET_SIZE     = 2,
  parameter int                       NUM_SETS     = 4,
  parameter int                       OFFSET_WIDTH = 4,
  parameter cache_pkg::replace_mode_e REPLACE_MODE = cache_pkg::REPL_LRU,
  localparam int INDEX_WIDTH = $clog2(NUM_SETS),
  localparam int TAG_WIDTH   = cache_pkg::ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH,
  localparam int WORD_BITS   = OFFSET_WIDTH - cache_pkg::BYTE_OFFSET_WIDTH
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  cache_pkg::ctrl_t     control_i,
  input  cache_pkg::addr_t     addr_i,
  input  cache_pkg::word_t     write_data_i,
  input  cache_pkg::addr_t     mem_addr_i,
  input  cache_pkg::word_t     mem_read_data_i,
  output logic                 hit_o,
  output logic                 dirty_o,
  output logic [TAG_WIDTH-1:0] tag_o,
  output cache_pkg::word_t     read_data_o
);

  logic write_en, set_valid, set_dirty, strategy_en, offset_sel;

  logic [SET_SIZE-1:0]  write_en_line;
  logic [SET_SIZE-1:0]  valid_line, dirty_line, hit_line, out_line;
  logic [SET_SIZE-1:0]  mask;
  logic [TAG_WIDTH-1:0] tag_line [SET_SIZE];
  cache_pkg::word_t     read_data_line [SET_SIZE];

  logic [TAG_WIDTH-1:0] set_tag;
  logic [WORD_BITS-1:0] offset;
  cache_pkg::word_t     write_data;

  assign {write_en, set_valid, set_dirty, strategy_en, offset_sel} = control_i;

  assign set_tag    = addr_i[cache_pkg::ADDR_WIDTH-1 -: TAG_WIDTH];
  assign offset     = offset_sel ? addr_i[OFFSET_WIDTH-1 -: WORD_BITS]
                                 : mem_addr_i[OFFSET_WIDTH-1 -: WORD_BITS];
  assign write_data = offset_sel ? write_data_i : mem_read_data_i;

  assign hit_o         = |hit_line;
  assign mask          = hit_o ? hit_line : out_line; // Victim way on a miss.
  assign write_en_line = write_en ? mask : '0;

  always_comb begin
    dirty_o     = 1'b0;
    tag_o       = '0;
    read_data_o = '0;
    for (int i = 0; i < SET_SIZE; i++) begin
      if (mask[i]) begin
        dirty_o     = dirty_line[i];
        tag_o       = tag_line[i];
        read_data_o = read_data_line[i];
      end
    end
  end

  replace_controller #(
    .SET_SIZE    (SET_SIZE),
    .REPLACE_MODE(REPLACE_MODE)
  ) u_replace_controller (
    .clk_i,
    .rst_n_i,
    .en_i        (strategy_en),
    .valid_line_i(valid_line),
    .hit_line_i  (hit_line),
    .out_line_o  (out_line)
  );

  for (genvar w = 0; w < SET_SIZE; w++) begin : g_line
    cache_line #(
      .NUM_SETS    (NUM_SETS),
      .OFFSET_WIDTH(OFFSET_WIDTH)
    ) u_line (
      .clk_i,
      .rst_n_i,
      .write_en_i  (write_en_line[w]),
      .set_valid_i (set_valid),
      .set_dirty_i (set_dirty),
      .set_tag_i   (set_tag),
      .offset_i    (offset),
      .write_data_i(write_data),
      .valid_o     (valid_line[w]),
      .dirty_o     (dirty_line[w]),
      .tag_o       (tag_line[w]),
      .hit_o       (hit_line[w]),
      .read_data_o (read_data_line[w])
    );
  end

endmodule : cache_set

// ==== logic/cache_controller.sv ====
`timescale 1ns/1ps

module cache_controller #(
  parameter int  NUM_SETS     = 4,
  parameter int  OFFSET_WIDTH = 4,
  localparam int INDEX_WIDTH  = $clog2(NUM_SETS),
  localparam int TAG_WIDTH    = cache_pkg::ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH,
  localparam int WORD_BITS    = OFFSET_WIDTH - cache_pkg::BYTE_OFFSET_WIDTH
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 req_i,
  input  logic                 we_i,
  input  cache_pkg::addr_t     addr_i,
  input  logic                 hit_i,
  input  logic                 dirty_i,
  input  logic [TAG_WIDTH-1:0] tag_i,
  input  logic                 mem_ack_i,
  output cache_pkg::ctrl_t     control_o,
  output logic                 mem_req_o,
  output logic                 mem_we_o,
  output cache_pkg::addr_t     mem_addr_o,
  output logic                 done_o
);

  // Control words, fields as in cache_pkg::ctrl_t.
  localparam cache_pkg::ctrl_t CTRL_WRITE_HIT = 5'b11111;
  localparam cache_pkg::ctrl_t CTRL_READ_HIT  = 5'b00010;
  localparam cache_pkg::ctrl_t CTRL_REFILL    = 5'b11000;

  cache_pkg::cache_state_e state_q, state_d;
  logic [WORD_BITS-1:0]    cnt_q, cnt_d;
  logic [TAG_WIDTH-1:0]    mem_tag;
  logic [WORD_BITS-1:0]    mem_word;
  logic                    last_word;

  assign last_word = (cnt_q == {WORD_BITS{1'b1}});

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= cache_pkg::ST_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  always_comb begin
    state_d   = state_q;
    cnt_d     = cnt_q;
    control_o = '0;
    case (state_q)
      cache_pkg::ST_IDLE: begin
        if (req_i) state_d = cache_pkg::ST_COMPARE;
      end
      cache_pkg::ST_COMPARE: begin
        cnt_d = '0;
        if (hit_i) begin
          control_o = we_i ? CTRL_WRITE_HIT : CTRL_READ_HIT;
          state_d   = cache_pkg::ST_DONE;
        end else if (dirty_i) begin
          state_d = cache_pkg::ST_WRITEBACK; // Victim must go out first.
        end else begin
          state_d = cache_pkg::ST_REFILL;
        end
      end
      cache_pkg::ST_WRITEBACK: begin
        if (mem_ack_i) begin
          cnt_d = cnt_q + 1'b1; // Wraps to 0 for the refill.
          if (last_word) state_d = cache_pkg::ST_REFILL;
        end
      end
      cache_pkg::ST_REFILL: begin
        if (mem_ack_i) begin
          control_o = CTRL_REFILL;
          cnt_d     = cnt_q + 1'b1;
          if (last_word) state_d = cache_pkg::ST_COMPARE;
        end
      end
      cache_pkg::ST_DONE: begin
        state_d = cache_pkg::ST_IDLE;
      end
      default: begin
        state_d = cache_pkg::ST_IDLE;
      end
    endcase
  end

  // Write-back goes to the victim's address, refill to the requested one.
  assign mem_tag = (state_q == cache_pkg::ST_WRITEBACK) ? tag_i
                 : addr_i[cache_pkg::ADDR_WIDTH-1 -: TAG_WIDTH];

  // Outside memory transfers the word field follows the processor address.
  assign mem_word = mem_req_o ? cnt_q : addr_i[OFFSET_WIDTH-1 -: WORD_BITS];

  assign mem_addr_o = {mem_tag, addr_i[OFFSET_WIDTH +: INDEX_WIDTH], mem_word,
                       {cache_pkg::BYTE_OFFSET_WIDTH{1'b0}}};

  assign mem_req_o = (state_q == cache_pkg::ST_WRITEBACK) || (state_q == cache_pkg::ST_REFILL);
  assign mem_we_o  = (state_q == cache_pkg::ST_WRITEBACK);
  assign done_o    = (state_q == cache_pkg::ST_DONE);

endmodule : cache_controller

// ==== logic/cache_top.sv ====
`timescale 1ns/1ps

module cache_top #(
  parameter int                       SET_SIZE     = 2,
  parameter int                       NUM_SETS     = 4,
  parameter int                       OFFSET_WIDTH = 4,
  parameter cache_pkg::replace_mode_e REPLACE_MODE = cache_pkg::REPL_LRU,
  localparam int INDEX_WIDTH = $clog2(NUM_SETS),
  localparam int TAG_WIDTH   = cache_pkg::ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             req_i,
  input  logic             we_i,
  input  cache_pkg::addr_t addr_i,
  input  cache_pkg::word_t wdata_i,
  input  cache_pkg::word_t mem_rdata_i,
  input  logic             mem_ack_i,
  output logic             done_o,
  output cache_pkg::word_t rdata_o,
  output logic             mem_req_o,
  output logic             mem_we_o,
  output cache_pkg::addr_t mem_addr_o,
  output cache_pkg::word_t mem_wdata_o
);

  cache_pkg::ctrl_t       control;
  cache_pkg::ctrl_t       set_control [NUM_SETS];
  logic [INDEX_WIDTH-1:0] index;
  logic [NUM_SETS-1:0]    set_hit, set_dirty;
  logic [TAG_WIDTH-1:0]   set_tag [NUM_SETS];
  cache_pkg::word_t       set_rdata [NUM_SETS];

  assign index = addr_i[OFFSET_WIDTH +: INDEX_WIDTH];

  for (genvar s = 0; s < NUM_SETS; s++) begin : g_set
    assign set_control[s] = (index == INDEX_WIDTH'(s)) ? control : '0; // Only the indexed set acts.

    cache_set #(
      .SET_SIZE    (SET_SIZE),
      .NUM_SETS    (NUM_SETS),
      .OFFSET_WIDTH(OFFSET_WIDTH),
      .REPLACE_MODE(REPLACE_MODE)
    ) u_set (
      .clk_i,
      .rst_n_i,
      .control_i      (set_control[s]),
      .addr_i         (addr_i),
      .write_data_i   (wdata_i),
      .mem_addr_i     (mem_addr_o),
      .mem_read_data_i(mem_rdata_i),
      .hit_o          (set_hit[s]),
      .dirty_o        (set_dirty[s]),
      .tag_o          (set_tag[s]),
      .read_data_o    (set_rdata[s])
    );
  end

  cache_controller #(
    .NUM_SETS    (NUM_SETS),
    .OFFSET_WIDTH(OFFSET_WIDTH)
  ) u_controller (
    .clk_i,
    .rst_n_i,
    .req_i,
    .we_i,
    .addr_i,
    .hit_i     (set_hit[index]),
    .dirty_i   (set_dirty[index]),
    .tag_i     (set_tag[index]),
    .mem_ack_i,
    .control_o (control),
    .mem_req_o,
    .mem_we_o,
    .mem_addr_o,
    .done_o
  );

  assign rdata_o     = set_rdata[index];
  assign mem_wdata_o = set_rdata[index]; // Victim word during write-back.

endmodule : cache_top

// ==== tests/mem_model.sv ====
`timescale 1ns/1ps

module mem_model #(
  parameter int ACK_DELAY = 3,
  parameter int DEPTH     = 4096
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             req_i,
  input  logic             we_i,
  input  cache_pkg::addr_t addr_i,
  input  cache_pkg::word_t wdata_i,
  input  cache_pkg::addr_t peek_addr_i,
  output logic             ack_o,
  output cache_pkg::word_t rdata_o,
  output cache_pkg::word_t peek_data_o,
  output int unsigned      write_count_o
);

  localparam int IDX_WIDTH = $clog2(DEPTH);

  cache_pkg::word_t     mem [DEPTH];
  int unsigned          wait_cnt;
  logic [IDX_WIDTH-1:0] idx;

  assign idx         = addr_i[IDX_WIDTH+1:2]; // Word address.
  assign peek_data_o = mem[peek_addr_i[IDX_WIDTH+1:2]];

  // Every word starts from a value spread over its whole word index.
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = (i * 32'h9e3779b1) ^ 32'h5ca1ab1e;
    end
  end

  // One word per request, acknowledged ACK_DELAY cycles after it rises.
  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_o         <= 1'b0;
      rdata_o       <= '0;
      wait_cnt      <= 0;
      write_count_o <= 0;
    end else begin
      ack_o <= 1'b0;
      if (req_i && !ack_o) begin
        if (wait_cnt == ACK_DELAY - 1) begin
          ack_o    <= 1'b1;
          wait_cnt <= 0;
          if (we_i) begin
            mem[idx]      <= wdata_i;
            write_count_o <= write_count_o + 1; // Logged write.
          end else begin
            rdata_o <= mem[idx];
          end
        end else begin
          wait_cnt <= wait_cnt + 1;
        end
      end
    end
  end

endmodule : mem_model

// ==== tests/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb;

  localparam int                       SET_SIZE       = 2;
  localparam int                       NUM_SETS       = 4;
  localparam int                       OFFSET_WIDTH   = 4;
  localparam cache_pkg::replace_mode_e REPLACE_MODE   = cache_pkg::REPL_LRU;
  localparam int                       INDEX_WIDTH    = $clog2(NUM_SETS);
  localparam int                       WORDS_PER_LINE = 2 ** (OFFSET_WIDTH - 2);
  localparam int                       MEM_WORDS      = 4096;
  localparam int                       TIMEOUT        = 200;

  logic             clk = 1'b0;
  logic             rst_n;
  logic             req;
  logic             we;
  cache_pkg::addr_t addr;
  cache_pkg::word_t wdata;
  logic             done;
  cache_pkg::word_t rdata;
  logic             mem_req, mem_we, mem_ack;
  cache_pkg::addr_t mem_addr, peek_addr;
  cache_pkg::word_t mem_wdata, mem_rdata, peek_data;
  int unsigned      mem_writes;

  cache_pkg::word_t shadow [MEM_WORDS]; // Expected memory image, by word address.
  int               check_count = 0;
  int               error_count = 0;

  always #50 clk = ~clk; // 100 ns period.

  cache_top #(
    .SET_SIZE    (SET_SIZE),
    .NUM_SETS    (NUM_SETS),
    .OFFSET_WIDTH(OFFSET_WIDTH),
    .REPLACE_MODE(REPLACE_MODE)
  ) u_dut (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .req_i      (req),
    .we_i       (we),
    .addr_i     (addr),
    .wdata_i    (wdata),
    .mem_rdata_i(mem_rdata),
    .mem_ack_i  (mem_ack),
    .done_o     (done),
    .rdata_o    (rdata),
    .mem_req_o  (mem_req),
    .mem_we_o   (mem_we),
    .mem_addr_o (mem_addr),
    .mem_wdata_o(mem_wdata)
  );

  mem_model #(
    .ACK_DELAY(3),
    .DEPTH    (MEM_WORDS)
  ) u_mem (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .req_i        (mem_req),
    .we_i         (mem_we),
    .addr_i       (mem_addr),
    .wdata_i      (mem_wdata),
    .peek_addr_i  (peek_addr),
    .ack_o        (mem_ack),
    .rdata_o      (mem_rdata),
    .peek_data_o  (peek_data),
    .write_count_o(mem_writes)
  );

  function automatic cache_pkg::word_t fill_word(cache_pkg::addr_t byte_addr);
    return ((byte_addr >> 2) * 32'h9e3779b1) ^ 32'h5ca1ab1e;
  endfunction

  function automatic cache_pkg::addr_t make_addr(int unsigned tag, int unsigned index,
                                                 int unsigned word);
    return (tag << (INDEX_WIDTH + OFFSET_WIDTH)) | (index << OFFSET_WIDTH) | (word << 2);
  endfunction

  task automatic check_equal(input string test_name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    check_count++;
    assert (actual === expected) else begin
      $display("Error in %s: %s expected %h, got %h", test_name, what, expected, actual);
      error_count++;
    end
  endtask

  // Runs one processor access and watches the memory side while it is pending.
  task automatic drive_access(input string test_name, input logic write,
                              input cache_pkg::addr_t a, input cache_pkg::word_t data,
                              output cache_pkg::word_t read_value, output logic used_mem,
                              output int cycles);
    logic finished;
    finished   = 1'b0;
    used_mem   = 1'b0;
    cycles     = 0;
    read_value = '0;
    req        = 1'b1;
    we         = write;
    addr       = a;
    wdata      = data;
    while (!finished && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
      used_mem = used_mem | mem_req;
      if (done) begin
        finished   = 1'b1;
        read_value = rdata; // Valid with the done pulse.
      end
    end
    check_count++;
    assert (finished) else begin
      $display("Timeout in %s: no done pulse within %0d cycles for address %h",
               test_name, TIMEOUT, a);
      error_count++;
    end
    req = 1'b0;
    we  = 1'b0;
    @(negedge clk); // Controller is back in idle.
    if (write) shadow[a >> 2] = data;
  endtask

  task automatic read_and_check(input string test_name, input cache_pkg::addr_t a,
                                output logic used_mem, output int cycles);
    cache_pkg::word_t value;
    drive_access(test_name, 1'b0, a, '0, value, used_mem, cycles);
    check_equal(test_name, "read data", shadow[a >> 2], value);
  endtask

  task automatic write_word(input string test_name, input cache_pkg::addr_t a,
                            input cache_pkg::word_t data, output logic used_mem);
    cache_pkg::word_t ignored;
    int               cycles;
    drive_access(test_name, 1'b1, a, data, ignored, used_mem, cycles);
  endtask

  task automatic peek_memory(input cache_pkg::addr_t a, output cache_pkg::word_t value);
    peek_addr = a;
    @(negedge clk);
    value = peek_data;
  endtask

  task automatic test_read_miss_then_hit();
    string            name;
    cache_pkg::addr_t a;
    logic             used_mem;
    int               cycles;
    name = "test_read_miss_then_hit";
    a    = make_addr(1, 0, 0);
    read_and_check(name, a, used_mem, cycles); // Returns the preload pattern.
    check_equal(name, "memory request on miss", 1, used_mem);
    read_and_check(name, a, used_mem, cycles);
    check_equal(name, "memory request on hit", 0, used_mem);
    check_equal(name, "hit latency in cycles", 2, cycles);
  endtask

  task automatic test_write_hit();
    string            name;
    cache_pkg::addr_t a;
    logic             used_mem;
    int               cycles;
    int unsigned      writes_before;
    name = "test_write_hit";
    a    = make_addr(2, 1, 0);
    read_and_check(name, a, used_mem, cycles);
    writes_before = mem_writes;
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      write_word(name, make_addr(2, 1, w), $urandom(), used_mem);
      check_equal(name, "memory request on write hit", 0, used_mem);
      read_and_check(name, make_addr(2, 1, w), used_mem, cycles);
      check_equal(name, "memory request on read hit", 0, used_mem);
    end
    check_equal(name, "memory write count", writes_before, mem_writes);
  endtask

  task automatic test_dirty_writeback();
    string            name;
    cache_pkg::addr_t a;
    cache_pkg::word_t value;
    logic             used_mem;
    int               cycles;
    name = "test_dirty_writeback";
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      write_word(name, make_addr(10, 2, w), $urandom(), used_mem);
    end
    for (int t = 1; t <= SET_SIZE; t++) begin
      read_and_check(name, make_addr(10 + t, 2, 0), used_mem, cycles);
    end
    // The dirty line must now sit in memory at its own addresses.
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      a = make_addr(10, 2, w);
      peek_memory(a, value);
      check_equal(name, "written-back word", shadow[a >> 2], value);
    end
    read_and_check(name, make_addr(10, 2, 0), used_mem, cycles);
    check_equal(name, "memory request after eviction", 1, used_mem);
  endtask

  task automatic test_lru_order();
    string name;
    logic  used_mem;
    int    cycles;
    name = "test_lru_order";
    if (SET_SIZE != 2 || REPLACE_MODE != cache_pkg::REPL_LRU) begin
      $display("Skipping %s, it needs 2 ways with LRU replacement", name);
    end else begin
      read_and_check(name, make_addr(20, 3, 0), used_mem, cycles); // A
      read_and_check(name, make_addr(21, 3, 0), used_mem, cycles); // B
      read_and_check(name, make_addr(20, 3, 0), used_mem, cycles); // A again.
      read_and_check(name, make_addr(22, 3, 0), used_mem, cycles); // C evicts B.
      read_and_check(name, make_addr(20, 3, 0), used_mem, cycles);
      check_equal(name, "memory request for A", 0, used_mem);
      read_and_check(name, make_addr(21, 3, 0), used_mem, cycles);
      check_equal(name, "memory request for B", 1, used_mem);
    end
  endtask

  task automatic test_random_traffic();
    string       name;
    logic        used_mem;
    int          cycles;
    int unsigned tag;
    int unsigned index;
    name = "test_random_traffic";
    for (int n = 0; n < 200; n++) begin
      tag   = 30 + ($urandom() % 6); // Six tags per index force evictions.
      index = $urandom() % NUM_SETS;
      if ($urandom() % 2 == 1) begin
        write_word(name, make_addr(tag, index, $urandom() % WORDS_PER_LINE), $urandom(),
                   used_mem);
      end else begin
        read_and_check(name, make_addr(tag, index, $urandom() % WORDS_PER_LINE), used_mem,
                       cycles);
      end
    end
  endtask

  initial begin
    int unsigned first_draw;
    first_draw = $urandom(32'h998b9877); // Seeds the generator for the whole run.
    rst_n      = 1'b0;
    req        = 1'b0;
    we         = 1'b0;
    addr       = '0;
    wdata      = '0;
    peek_addr  = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      shadow[i] = fill_word(cache_pkg::addr_t'(i) << 2);
    end
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    test_read_miss_then_hit();
    test_write_hit();
    test_dirty_writeback();
    test_lru_order();
    test_random_traffic();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : cache_tb

// ==== list.f ====
logic/cache_pkg.sv
logic/cache_line.sv
logic/replace_controller.sv
logic/cache_set.sv
logic/cache_controller.sv
logic/cache_top.sv
tests/mem_model.sv
tests/cache_tb.sv
